// ==== include/axi_mem_settings.svh ====
`ifndef AXI_MEM_SETTINGS_SVH
`define AXI_MEM_SETTINGS_SVH

// axi bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 64
// one strobe bit per data byte
`define AXI_STRB_W 8
`define AXI_ID_W 4

// on-chip memory, 64-bit words
`define MEM_WORDS 1024
// word index width, log2 of MEM_WORDS
`define MEM_IDX_W 10
// first byte address served
`define MEM_BASE 32'h8000_0000

`endif

// ==== logic/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

  // response codes on r and b
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // burst length, beats minus one
  // max 8 beats per incr burst here
  typedef logic [2:0] axi_len_t;

endpackage

`default_nettype wire

// ==== logic/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  // core-side operation kind
  typedef enum logic {
    LSU_LOAD  = 1'b0,
    LSU_STORE = 1'b1
  } lsu_op_e;

endpackage

`default_nettype wire

// ==== logic/mem_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module mem_array (
  input  wire logic                   clock,
  // write port
  input  wire logic                   we_i,
  input  wire logic [`MEM_IDX_W-1:0]  widx_i,
  input  wire logic [`AXI_DATA_W-1:0] wdata_i,
  input  wire logic [`AXI_STRB_W-1:0] wstrb_i,
  // read port, one cycle latency
  input  wire logic [`MEM_IDX_W-1:0]  ridx_i,
  output logic [`AXI_DATA_W-1:0]      rdata_o
);

  logic [`AXI_DATA_W-1:0] mem_q [`MEM_WORDS];

  // byte-lane write
  always_ff @(posedge clock) begin
    if (we_i) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (wstrb_i[b]) mem_q[widx_i][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  // same-index collision returns the old word
  always_ff @(posedge clock) begin
    rdata_o <= mem_q[ridx_i];
  end

endmodule

`default_nettype wire

// ==== logic/lsu_axi_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module lsu_axi_bridge (
  input  wire logic                   clock,
  input  wire logic                   reset_n,
  // core request
  input  wire logic                   req_valid_i,
  output logic                        req_ready_o,
  input  wire lsu_pkg::lsu_op_e       req_op_i,
  input  wire logic [`AXI_ID_W-1:0]   req_id_i,
  input  wire logic [`AXI_ADDR_W-1:0] req_addr_i,
  input  wire logic [`AXI_DATA_W-1:0] req_wdata_i,
  input  wire logic [`AXI_STRB_W-1:0] req_wstrb_i,
  input  wire axi_pkg::axi_len_t      req_len_i,
  // core response
  output logic                        resp_valid_o,
  input  wire logic                   resp_ready_i,
  output logic [`AXI_ID_W-1:0]        resp_id_o,
  output logic [`AXI_DATA_W-1:0]      resp_data_o,
  output logic                        resp_last_o,
  output logic                        resp_err_o,
  // ar channel
  output logic                        ar_valid_o,
  input  wire logic                   ar_ready_i,
  output logic [`AXI_ADDR_W-1:0]      ar_addr_o,
  output logic [`AXI_ID_W-1:0]        ar_id_o,
  output axi_pkg::axi_len_t           ar_len_o,
  // r channel
  input  wire logic                   r_valid_i,
  output logic                        r_ready_o,
  input  wire logic [`AXI_DATA_W-1:0] r_data_i,
  input  wire axi_pkg::axi_resp_e     r_resp_i,
  input  wire logic                   r_last_i,
  input  wire logic [`AXI_ID_W-1:0]   r_id_i,
  // aw channel
  output logic                        aw_valid_o,
  input  wire logic                   aw_ready_i,
  output logic [`AXI_ADDR_W-1:0]      aw_addr_o,
  output logic [`AXI_ID_W-1:0]        aw_id_o,
  // w channel
  output logic                        w_valid_o,
  input  wire logic                   w_ready_i,
  output logic [`AXI_DATA_W-1:0]      w_data_o,
  output logic [`AXI_STRB_W-1:0]      w_strb_o,
  output logic                        w_last_o,
  // b channel
  input  wire logic                   b_valid_i,
  output logic                        b_ready_o,
  input  wire axi_pkg::axi_resp_e     b_resp_i,
  input  wire logic [`AXI_ID_W-1:0]   b_id_i
);
  import axi_pkg::*;
  import lsu_pkg::*;

  typedef enum logic [2:0] {ST_IDLE, ST_RADDR, ST_RDATA, ST_WRITE, ST_WRESP} state_e;

  state_e                 state_q;
  logic                   init_q;
  logic                   aw_done_q, w_done_q;
  logic                   b_pend_q;
  logic                   b_err_q;
  logic [`AXI_ID_W-1:0]   b_id_q;
  // captured request
  logic [`AXI_ADDR_W-1:0] addr_q;
  logic [`AXI_ID_W-1:0]   id_q;
  logic [`AXI_DATA_W-1:0] wdata_q;
  logic [`AXI_STRB_W-1:0] wstrb_q;
  axi_len_t               len_q;
  logic                   req_hs, ar_hs, r_hs, aw_hs, w_hs, b_hs;
  logic                   in_rdata;

  assign req_hs   = req_valid_i && req_ready_o;
  assign ar_hs    = ar_valid_o && ar_ready_i;
  assign r_hs     = r_valid_i && r_ready_o;
  assign aw_hs    = aw_valid_o && aw_ready_i;
  assign w_hs     = w_valid_o && w_ready_i;
  assign b_hs     = b_valid_i && b_ready_o;
  assign in_rdata = (state_q == ST_RDATA);

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state_q   <= ST_IDLE;
      init_q    <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      b_pend_q  <= 1'b0;
    end else begin
      // ready held off for the first cycle out of reset
      init_q <= 1'b1;
      case (state_q)
        ST_IDLE: if (req_hs) begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          state_q   <= (req_op_i == LSU_LOAD) ? ST_RADDR : ST_WRITE;
        end
        ST_RADDR: if (ar_hs) state_q <= ST_RDATA;
        ST_RDATA: if (r_hs && r_last_i) state_q <= ST_IDLE;
        ST_WRITE: begin
          // aw and w complete in either order
          if (aw_hs) aw_done_q <= 1'b1;
          if (w_hs) w_done_q <= 1'b1;
          if (aw_done_q && w_done_q) state_q <= ST_WRESP;
        end
        ST_WRESP: if (b_hs) begin
          b_pend_q <= 1'b1;
          state_q  <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
      // store response leaves once the core takes it
      if (b_pend_q && resp_ready_i) b_pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (req_hs) begin
      addr_q  <= req_addr_i;
      id_q    <= req_id_i;
      wdata_q <= req_wdata_i;
      wstrb_q <= req_wstrb_i;
      len_q   <= req_len_i;
    end
    if (b_hs) begin
      b_id_q  <= b_id_i;
      b_err_q <= (b_resp_i != RESP_OKAY);
    end
  end

  // no new request while a store response waits
  assign req_ready_o = init_q && (state_q == ST_IDLE) && !b_pend_q;

  assign ar_valid_o = (state_q == ST_RADDR);
  assign ar_addr_o  = addr_q;
  assign ar_id_o    = id_q;
  assign ar_len_o   = len_q;
  // core back-pressure goes straight to r
  assign r_ready_o  = in_rdata && resp_ready_i;

  assign aw_valid_o = (state_q == ST_WRITE) && !aw_done_q;
  assign aw_addr_o  = addr_q;
  assign aw_id_o    = id_q;
  assign w_valid_o  = (state_q == ST_WRITE) && !w_done_q;
  assign w_data_o   = wdata_q;
  assign w_strb_o   = wstrb_q;
  // single-beat writes only
  assign w_last_o   = 1'b1;
  assign b_ready_o  = (state_q == ST_WRESP);

  // r beats pass through, b is the registered copy
  assign resp_valid_o = in_rdata ? r_valid_i : b_pend_q;
  assign resp_id_o    = in_rdata ? r_id_i : b_id_q;
  assign resp_data_o  = in_rdata ? r_data_i : '0;
  assign resp_last_o  = in_rdata ? r_last_i : 1'b1;
  assign resp_err_o   = in_rdata ? (r_resp_i != RESP_OKAY) : b_err_q;

endmodule

`default_nettype wire

// ==== logic/axi_mem_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module axi_mem_slave (
  input  wire logic                   clock,
  input  wire logic                   reset_n,
  // ar channel
  input  wire logic                   ar_valid_i,
  output logic                        ar_ready_o,
  input  wire logic [`AXI_ADDR_W-1:0] ar_addr_i,
  input  wire logic [`AXI_ID_W-1:0]   ar_id_i,
  input  wire axi_pkg::axi_len_t      ar_len_i,
  // r channel
  output logic                        r_valid_o,
  input  wire logic                   r_ready_i,
  output logic [`AXI_DATA_W-1:0]      r_data_o,
  output axi_pkg::axi_resp_e          r_resp_o,
  output logic                        r_last_o,
  output logic [`AXI_ID_W-1:0]        r_id_o,
  // aw channel
  input  wire logic                   aw_valid_i,
  output logic                        aw_ready_o,
  input  wire logic [`AXI_ADDR_W-1:0] aw_addr_i,
  input  wire logic [`AXI_ID_W-1:0]   aw_id_i,
  // w channel
  input  wire logic                   w_valid_i,
  output logic                        w_ready_o,
  input  wire logic [`AXI_DATA_W-1:0] w_data_i,
  input  wire logic [`AXI_STRB_W-1:0] w_strb_i,
  input  wire logic                   w_last_i,
  // b channel
  output logic                        b_valid_o,
  input  wire logic                   b_ready_i,
  output axi_pkg::axi_resp_e          b_resp_o,
  output logic [`AXI_ID_W-1:0]        b_id_o,
  // memory ports
  output logic                        mem_we_o,
  output logic [`MEM_IDX_W-1:0]       mem_widx_o,
  output logic [`AXI_DATA_W-1:0]      mem_wdata_o,
  output logic [`AXI_STRB_W-1:0]      mem_wstrb_o,
  output logic [`MEM_IDX_W-1:0]       mem_ridx_o,
  input  wire logic [`AXI_DATA_W-1:0] mem_rdata_i
);
  import axi_pkg::*;

  // memory size in bytes
  localparam int unsigned MEM_SPAN = `MEM_WORDS * (`AXI_DATA_W / 8);

  typedef enum logic [1:0] {R_IDLE, R_FETCH, R_DATA} r_state_e;
  typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} w_state_e;

  // byte address inside the memory window
  function automatic logic in_range(input logic [`AXI_ADDR_W-1:0] addr);
    logic [`AXI_ADDR_W-1:0] off;
    off = addr - `MEM_BASE;
    return off < MEM_SPAN;
  endfunction

  // 8-byte word index from the window offset
  function automatic logic [`MEM_IDX_W-1:0] word_idx(input logic [`AXI_ADDR_W-1:0] addr);
    logic [`AXI_ADDR_W-1:0] off;
    off = addr - `MEM_BASE;
    return off[`MEM_IDX_W+2:3];
  endfunction

  r_state_e               r_state_q;
  axi_len_t               r_cnt_q, r_len_q;
  logic [`AXI_ADDR_W-1:0] r_addr_q, r_addr_nxt;
  logic [`AXI_ID_W-1:0]   r_id_q;
  logic                   ar_hs, r_hs, r_ok;

  w_state_e               w_state_q;
  logic [`AXI_ADDR_W-1:0] w_addr_q;
  logic [`AXI_ID_W-1:0]   w_id_q;
  axi_resp_e              b_resp_q;
  logic                   aw_hs, w_hs, b_hs, w_ok;

  assign ar_hs      = ar_valid_i && ar_ready_o;
  assign r_hs       = r_valid_o && r_ready_i;
  assign aw_hs      = aw_valid_i && aw_ready_o;
  assign w_hs       = w_valid_i && w_ready_o;
  assign b_hs       = b_valid_o && b_ready_i;
  assign r_addr_nxt = r_addr_q + (`AXI_DATA_W / 8);
  assign r_ok       = in_range(r_addr_q);
  assign w_ok       = in_range(w_addr_q);

  // read fsm, fetch cycle covers the array latency
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      r_state_q <= R_IDLE;
      r_cnt_q   <= '0;
    end else begin
      case (r_state_q)
        R_IDLE: if (ar_hs) begin
          r_state_q <= R_FETCH;
          r_cnt_q   <= '0;
        end
        R_FETCH: r_state_q <= R_DATA;
        R_DATA: if (r_hs) begin
          if (r_last_o) r_state_q <= R_IDLE;
          else r_cnt_q <= r_cnt_q + 1'b1;
        end
        default: r_state_q <= R_IDLE;
      endcase
    end
  end

  // burst address counter, incr only
  always_ff @(posedge clock) begin
    if (ar_hs) begin
      r_addr_q <= ar_addr_i;
      r_len_q  <= ar_len_i;
      r_id_q   <= ar_id_i;
    end else if (r_hs) begin
      r_addr_q <= r_addr_nxt;
    end
  end

  // next word is fetched on the beat handshake
  // while stalled the same word is read again
  assign mem_ridx_o = r_hs ? word_idx(r_addr_nxt) : word_idx(r_addr_q);

  assign ar_ready_o = (r_state_q == R_IDLE);
  assign r_valid_o  = (r_state_q == R_DATA);
  assign r_data_o   = r_ok ? mem_rdata_i : '0;
  assign r_resp_o   = r_ok ? RESP_OKAY : RESP_SLVERR;
  assign r_last_o   = (r_cnt_q == r_len_q);
  assign r_id_o     = r_id_q;

  // write fsm
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      w_state_q <= W_IDLE;
    end else begin
      case (w_state_q)
        W_IDLE: if (aw_hs) w_state_q <= W_DATA;
        W_DATA: if (w_hs && w_last_i) w_state_q <= W_RESP;
        W_RESP: if (b_hs) w_state_q <= W_IDLE;
        default: w_state_q <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (aw_hs) begin
      w_addr_q <= aw_addr_i;
      w_id_q   <= aw_id_i;
    end
    if (w_hs) b_resp_q <= w_ok ? RESP_OKAY : RESP_SLVERR;
  end

  assign aw_ready_o = (w_state_q == W_IDLE);
  assign w_ready_o  = (w_state_q == W_DATA);
  assign b_valid_o  = (w_state_q == W_RESP);
  assign b_resp_o   = b_resp_q;
  assign b_id_o     = w_id_q;

  // out-of-range writes never reach the array
  assign mem_we_o    = w_hs && w_ok;
  assign mem_widx_o  = word_idx(w_addr_q);
  assign mem_wdata_o = w_data_i;
  assign mem_wstrb_o = w_strb_i;

endmodule

`default_nettype wire

// ==== logic/axi_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module axi_mem_top (
  input  wire logic                   clock,
  input  wire logic                   reset_n,
  input  wire logic                   req_valid_i,
  output logic                        req_ready_o,
  input  wire lsu_pkg::lsu_op_e       req_op_i,
  input  wire logic [`AXI_ID_W-1:0]   req_id_i,
  input  wire logic [`AXI_ADDR_W-1:0] req_addr_i,
  input  wire logic [`AXI_DATA_W-1:0] req_wdata_i,
  input  wire logic [`AXI_STRB_W-1:0] req_wstrb_i,
  input  wire axi_pkg::axi_len_t      req_len_i,
  output logic                        resp_valid_o,
  input  wire logic                   resp_ready_i,
  output logic [`AXI_ID_W-1:0]        resp_id_o,
  output logic [`AXI_DATA_W-1:0]      resp_data_o,
  output logic                        resp_last_o,
  output logic                        resp_err_o
);
  import axi_pkg::*;

  // axi between bridge and slave
  logic                   ar_valid, ar_ready;
  logic [`AXI_ADDR_W-1:0] ar_addr, aw_addr;
  logic [`AXI_ID_W-1:0]   ar_id, r_id, aw_id, b_id;
  axi_len_t               ar_len;
  logic                   r_valid, r_ready, r_last;
  logic [`AXI_DATA_W-1:0] r_data, w_data;
  axi_resp_e              r_resp, b_resp;
  logic                   aw_valid, aw_ready, w_valid, w_ready, w_last;
  logic [`AXI_STRB_W-1:0] w_strb;
  logic                   b_valid, b_ready;
  // slave to array
  logic                   mem_we;
  logic [`MEM_IDX_W-1:0]  mem_widx, mem_ridx;
  logic [`AXI_DATA_W-1:0] mem_wdata, mem_rdata;
  logic [`AXI_STRB_W-1:0] mem_wstrb;

  lsu_axi_bridge u_bridge (
    .clock(clock), .reset_n(reset_n),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_op_i(req_op_i),
    .req_id_i(req_id_i), .req_addr_i(req_addr_i), .req_wdata_i(req_wdata_i),
    .req_wstrb_i(req_wstrb_i), .req_len_i(req_len_i),
    .resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i), .resp_id_o(resp_id_o),
    .resp_data_o(resp_data_o), .resp_last_o(resp_last_o), .resp_err_o(resp_err_o),
    .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_addr_o(ar_addr),
    .ar_id_o(ar_id), .ar_len_o(ar_len),
    .r_valid_i(r_valid), .r_ready_o(r_ready), .r_data_i(r_data),
    .r_resp_i(r_resp), .r_last_i(r_last), .r_id_i(r_id),
    .aw_valid_o(aw_valid), .aw_ready_i(aw_ready), .aw_addr_o(aw_addr), .aw_id_o(aw_id),
    .w_valid_o(w_valid), .w_ready_i(w_ready), .w_data_o(w_data),
    .w_strb_o(w_strb), .w_last_o(w_last),
    .b_valid_i(b_valid), .b_ready_o(b_ready), .b_resp_i(b_resp), .b_id_i(b_id)
  );

  axi_mem_slave u_slave (
    .clock(clock), .reset_n(reset_n),
    .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr),
    .ar_id_i(ar_id), .ar_len_i(ar_len),
    .r_valid_o(r_valid), .r_ready_i(r_ready), .r_data_o(r_data),
    .r_resp_o(r_resp), .r_last_o(r_last), .r_id_o(r_id),
    .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_addr_i(aw_addr), .aw_id_i(aw_id),
    .w_valid_i(w_valid), .w_ready_o(w_ready), .w_data_i(w_data),
    .w_strb_i(w_strb), .w_last_i(w_last),
    .b_valid_o(b_valid), .b_ready_i(b_ready), .b_resp_o(b_resp), .b_id_o(b_id),
    .mem_we_o(mem_we), .mem_widx_o(mem_widx), .mem_wdata_o(mem_wdata),
    .mem_wstrb_o(mem_wstrb), .mem_ridx_o(mem_ridx), .mem_rdata_i(mem_rdata)
  );

  mem_array u_mem (
    .clock(clock),
    .we_i(mem_we), .widx_i(mem_widx), .wdata_i(mem_wdata), .wstrb_i(mem_wstrb),
    .ridx_i(mem_ridx), .rdata_o(mem_rdata)
  );

endmodule

`default_nettype wire

// ==== dv/axi_mem_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module axi_mem_assert (
  input  wire logic                   clock,
  input  wire logic                   reset_n,
  input  wire logic                   ar_valid_i,
  input  wire logic                   ar_ready_i,
  input  wire axi_pkg::axi_len_t      ar_len_i,
  input  wire logic                   r_valid_i,
  input  wire logic                   r_ready_i,
  input  wire logic [`AXI_DATA_W-1:0] r_data_i,
  input  wire axi_pkg::axi_resp_e     r_resp_i,
  input  wire logic                   r_last_i,
  input  wire logic [`AXI_ID_W-1:0]   r_id_i,
  input  wire logic                   w_ready_i,
  input  wire logic                   b_valid_i,
  input  wire logic                   b_ready_i,
  input  wire axi_pkg::axi_resp_e     b_resp_i,
  input  wire logic [`AXI_ID_W-1:0]   b_id_i
);
  import axi_pkg::*;

  axi_len_t    len_q;
  axi_len_t    beat_q;
  int unsigned fail_cnt = 0;

  // beat number inside the current burst
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      beat_q <= '0;
    end else if (ar_valid_i && ar_ready_i) begin
      beat_q <= '0;
      len_q  <= ar_len_i;
    end else if (r_valid_i && r_ready_i) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  r_hold : assert property (@(posedge clock) disable iff (!reset_n)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i) && $stable(r_resp_i)
      && $stable(r_last_i) && $stable(r_id_i))
    else begin
      $error("r valid dropped or payload changed before ready");
      fail_cnt++;
    end

  b_hold : assert property (@(posedge clock) disable iff (!reset_n)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i) && $stable(b_id_i))
    else begin
      $error("b valid dropped or payload changed before ready");
      fail_cnt++;
    end

  // last only on beat len+1
  r_last_beat : assert property (@(posedge clock) disable iff (!reset_n)
    r_valid_i |-> (r_last_i == (beat_q == len_q)))
    else begin
      $error("r_last not on the final beat of the burst");
      fail_cnt++;
    end

  idle_after_reset : assert property (@(posedge clock)
    !reset_n |=> !r_valid_i && !b_valid_i && !w_ready_i)
    else begin
      $error("channel active right after reset");
      fail_cnt++;
    end

endmodule

bind axi_mem_slave axi_mem_assert u_assert (
  .clock(clock), .reset_n(reset_n),
  .ar_valid_i(ar_valid_i), .ar_ready_i(ar_ready_o), .ar_len_i(ar_len_i),
  .r_valid_i(r_valid_o), .r_ready_i(r_ready_i), .r_data_i(r_data_o),
  .r_resp_i(r_resp_o), .r_last_i(r_last_o), .r_id_i(r_id_o),
  .w_ready_i(w_ready_o),
  .b_valid_i(b_valid_o), .b_ready_i(b_ready_i), .b_resp_i(b_resp_o), .b_id_i(b_id_o)
);

`default_nettype wire

// ==== dv/axi_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module axi_mem_tb;
  import axi_pkg::*;
  import lsu_pkg::*;

  // traffic runs near 1100 cycles
  // fill alone takes about 72 x 8
  localparam int MAX_CYCLES = 4000;
  localparam int BEAT_BYTES = `AXI_DATA_W / 8;
  localparam int D = `AXI_DATA_W;
  // expected beat {is_load, id, last, err, data}
  localparam int EXP_W = D + `AXI_ID_W + 3;

  logic                   clock = 1'b0;
  logic                   reset_n;
  logic                   req_valid_i;
  logic                   req_ready_o;
  lsu_op_e                req_op_i;
  logic [`AXI_ID_W-1:0]   req_id_i;
  logic [`AXI_ADDR_W-1:0] req_addr_i;
  logic [`AXI_DATA_W-1:0] req_wdata_i;
  logic [`AXI_STRB_W-1:0] req_wstrb_i;
  axi_len_t               req_len_i;
  logic                   resp_valid_o, resp_ready_i, resp_last_o, resp_err_o;
  logic [`AXI_ID_W-1:0]   resp_id_o;
  logic [`AXI_DATA_W-1:0] resp_data_o;

  logic [EXP_W-1:0]       exp_q[$];
  // absent words of the reference memory read as zero
  logic [`AXI_DATA_W-1:0] ref_mem [int];
  logic [15:0]            lfsr_q = 16'd79;
  logic                   stall_en = 1'b0;
  int                     cycles = 0;
  int                     errors = 0;
  int                     checks = 0;
  int                     test_errors = 0;

  axi_mem_top DUT (
    .clock(clock), .reset_n(reset_n),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_op_i(req_op_i),
    .req_id_i(req_id_i), .req_addr_i(req_addr_i), .req_wdata_i(req_wdata_i),
    .req_wstrb_i(req_wstrb_i), .req_len_i(req_len_i),
    .resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i), .resp_id_o(resp_id_o),
    .resp_data_o(resp_data_o), .resp_last_o(resp_last_o), .resp_err_o(resp_err_o)
  );

  // 8 ns period
  always #4 clock = ~clock;

  // 16-bit fibonacci lfsr with taps 16 14 13 11
  // stepped once per returned bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v[i]   = fb;
    end
    return v;
  endfunction

  function automatic logic [`AXI_ADDR_W-1:0] addr_of(input int idx);
    return `MEM_BASE + BEAT_BYTES * idx;
  endfunction

  function automatic logic in_window(input logic [`AXI_ADDR_W-1:0] addr);
    return (addr >= `MEM_BASE) && (addr < (`MEM_BASE + BEAT_BYTES * `MEM_WORDS));
  endfunction

  function automatic int word_of(input logic [`AXI_ADDR_W-1:0] addr);
    return int'((addr - `MEM_BASE) >> 3);
  endfunction

  function automatic logic [`AXI_DATA_W-1:0] ref_word(input int idx);
    return ref_mem.exists(idx) ? ref_mem[idx] : '0;
  endfunction

  // expected response beat from the reference memory
  function automatic void predict_beat(input lsu_op_e op, input logic [`AXI_ADDR_W-1:0] addr,
                                       input axi_len_t len, input int beat,
                                       output logic [`AXI_DATA_W-1:0] data,
                                       output logic last, output logic err);
    logic [`AXI_ADDR_W-1:0] a;
    a    = addr + BEAT_BYTES * beat;
    err  = !in_window(a);
    last = (op == LSU_STORE) || (beat == int'(len));
    // out-of-range beats carry zero
    data = (op == LSU_STORE || err) ? '0 : ref_word(word_of(a));
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // next falling edge with random core back-pressure when enabled
  task automatic tick();
    @(negedge clock);
    resp_ready_i = stall_en ? (rand_bits(1) != 0) : 1'b1;
  endtask

  task automatic send_req(input lsu_op_e op, input logic [`AXI_ID_W-1:0] id,
                          input logic [`AXI_ADDR_W-1:0] addr,
                          input logic [`AXI_DATA_W-1:0] wdata,
                          input logic [`AXI_STRB_W-1:0] wstrb, input axi_len_t len);
    logic [`AXI_DATA_W-1:0] d;
    logic                   l;
    logic                   e;
    int                     n;
    tick();
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_id_i    = id;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_wstrb_i = wstrb;
    req_len_i   = len;
    // ready is registered so the value seen here holds at the next rising edge
    while (!req_ready_o) tick();
    tick();
    req_valid_i = 1'b0;
    n = (op == LSU_STORE) ? 1 : int'(len) + 1;
    for (int b = 0; b < n; b++) begin
      predict_beat(op, addr, len, b, d, l, e);
      exp_q.push_back({op == LSU_LOAD, id, l, e, d});
    end
    // byte-lane merge of the store
    if (op == LSU_STORE && in_window(addr)) begin
      d = ref_word(word_of(addr));
      for (int k = 0; k < `AXI_STRB_W; k++)
        if (wstrb[k]) d[8*k +: 8] = wdata[8*k +: 8];
      ref_mem[word_of(addr)] = d;
    end
  endtask

  task automatic end_test(input string name);
    while (exp_q.size() != 0) tick();
    $display("test %s done, %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  always @(posedge clock) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, %0d responses still outstanding",
               cycles, exp_q.size());
      $display("** FAIL **");
      $finish;
    end
  end

  // compare every response handshake against the queue
  always @(posedge clock) begin : compare
    logic [EXP_W-1:0] e;
    if (reset_n && req_valid_i && req_ready_o && exp_q.size() != 0) begin
      errors++;
      $display("error at %0t: request accepted while a response was pending", $time);
    end
    if (reset_n && resp_valid_o && resp_ready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("error at %0t: response arrived with none expected", $time);
      end else begin
        e = exp_q.pop_front();
        check_val("resp_id_o", e[D+`AXI_ID_W+1:D+2], resp_id_o);
        check_val("resp_last_o", e[D+1], resp_last_o);
        check_val("resp_err_o", e[D], resp_err_o);
        // store responses carry no data
        if (e[EXP_W-1]) check_val("resp_data_o", e[D-1:0], resp_data_o);
      end
    end
  end

  initial begin
    logic [`AXI_ADDR_W-1:0] a;
    logic [`AXI_DATA_W-1:0] d;
    logic [`AXI_STRB_W-1:0] s;
    logic [`AXI_ID_W-1:0]   id;
    axi_len_t               l;
    logic                   st;
    int                     n;
    int                     total;
    reset_n      = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = LSU_LOAD;
    req_id_i     = '0;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    req_wstrb_i  = '0;
    req_len_i    = '0;
    resp_ready_i = 1'b1;
    repeat (5) begin
      @(negedge clock);
      check_val("resp_valid_o", 1'b0, resp_valid_o);
    end
    reset_n = 1'b1;
    n = 0;
    while (!req_ready_o && n < 4) begin
      tick();
      check_val("resp_valid_o", 1'b0, resp_valid_o);
      n++;
    end
    if (!req_ready_o) begin
      errors++;
      $display("error: req_ready_o did not rise after reset");
    end
    // words 0..71 cover every burst of the window tests
    for (int i = 0; i < 72; i++) begin
      d = rand_bits(64);
      send_req(LSU_STORE, 4'(i), addr_of(i), d, '1, 3'd0);
    end
    end_test("fill");
    // test 1 stores a full word and loads it back with another id
    d = rand_bits(64);
    send_req(LSU_STORE, 4'h3, addr_of(5), d, 8'hFF, 3'd0);
    send_req(LSU_LOAD, 4'hA, addr_of(5), '0, '0, 3'd0);
    end_test("store_load");
    // test 2 uses partial strobes
    for (int i = 0; i < 6; i++) begin
      a  = addr_of(int'(rand_bits(6)));
      id = 4'(rand_bits(4));
      d  = rand_bits(64);
      s  = 8'(rand_bits(8));
      send_req(LSU_STORE, id, a, d, s, 3'd0);
      send_req(LSU_LOAD, ~id, a, '0, '0, 3'd0);
    end
    end_test("strobes");
    // test 3 walks every burst length
    for (int i = 0; i < 8; i++) begin
      a = addr_of(int'(rand_bits(6)));
      send_req(LSU_LOAD, 4'(i), a, '0, '0, axi_len_t'(i));
    end
    end_test("bursts");
    // test 4 fills the top words so the crossing burst reads known data
    send_req(LSU_STORE, 4'h1, addr_of(`MEM_WORDS - 2), rand_bits(64), '1, 3'd0);
    send_req(LSU_STORE, 4'h2, addr_of(`MEM_WORDS - 1), rand_bits(64), '1, 3'd0);
    // these two would alias word 0 and the top word
    send_req(LSU_STORE, 4'h4, addr_of(`MEM_WORDS), rand_bits(64), '1, 3'd0);
    send_req(LSU_STORE, 4'h5, addr_of(-1), rand_bits(64), '1, 3'd0);
    send_req(LSU_LOAD, 4'h6, addr_of(`MEM_WORDS), '0, '0, 3'd2);
    send_req(LSU_LOAD, 4'h7, addr_of(`MEM_WORDS - 2), '0, '0, 3'd3);
    send_req(LSU_LOAD, 4'h8, addr_of(0), '0, '0, 3'd0);
    send_req(LSU_LOAD, 4'h9, addr_of(`MEM_WORDS - 1), '0, '0, 3'd0);
    end_test("range");
    // test 5 issues requests back to back under random stalls
    stall_en = 1'b1;
    for (int i = 0; i < 12; i++) begin
      st = (rand_bits(1) != 0);
      a  = addr_of(int'(rand_bits(6)));
      id = 4'(rand_bits(4));
      d  = rand_bits(64);
      s  = 8'(rand_bits(8));
      l  = axi_len_t'(rand_bits(3));
      if (st) send_req(LSU_STORE, id, a, d, s, 3'd0);
      else send_req(LSU_LOAD, id, a, '0, '0, l);
    end
    end_test("stalls");
    stall_en = 1'b0;
    total = errors + DUT.u_slave.u_assert.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d, cycles %0d",
             checks, errors, DUT.u_slave.u_assert.fail_cnt, cycles);
    if (total == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
logic/axi_pkg.sv
logic/lsu_pkg.sv
logic/mem_array.sv
logic/lsu_axi_bridge.sv
logic/axi_mem_slave.sv
logic/axi_mem_top.sv
dv/axi_mem_assert.sv
dv/axi_mem_tb.sv

// ==== Bender.yml ====
package:
  name: axi_mem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/axi_pkg.sv
      - logic/lsu_pkg.sv
      - logic/mem_array.sv
      - logic/lsu_axi_bridge.sv
      - logic/axi_mem_slave.sv
      - logic/axi_mem_top.sv
      - target: test
        files:
          - dv/axi_mem_assert.sv
          - dv/axi_mem_tb.sv
